// ==== rtl/haar_pkg.sv ====
package haar_pkg;

	localparam int PIXEL_WIDTH = 8; // Unsigned grey level
	localparam int SUM_WIDTH = 12; // Wide enough for a 3 by 3 window of 8-bit pixels

	typedef logic [PIXEL_WIDTH-1:0] pixel_t;
	typedef logic [SUM_WIDTH-1:0] sum_t;

	// Frame progress as seen by the controller
	typedef enum logic [1:0]
	{
		ST_IDLE = 2'd0, // Waiting for the first frame start
		ST_FILL = 2'd1, // Rows above the first full window are still arriving
		ST_STREAM = 2'd2, // Every accepted pixel may close a window
		ST_DONE = 2'd3 // Last pixel seen, waiting for the next frame start
	} frame_state_t;

	localparam int DEF_FRAME_WIDTH = 10;
	localparam int DEF_FRAME_HEIGHT = 10;
	localparam int DEF_WIN_WIDTH = 3;
	localparam int DEF_WIN_HEIGHT = 3;
	localparam int DEF_CREDITS = 4; // Credits granted to the sender after reset

endpackage

// ==== rtl/window_counter.sv ====
`timescale 1ns/100ps

module window_counter
#(
	parameter int FRAME_WIDTH = haar_pkg::DEF_FRAME_WIDTH,
	parameter int FRAME_HEIGHT = haar_pkg::DEF_FRAME_HEIGHT
)
(
	input logic clk_os,
	input logic i_rst_n,
	input logic i_clear,
	input logic i_advance,
	output logic [$clog2(FRAME_WIDTH)-1:0] o_col,
	output logic [$clog2(FRAME_HEIGHT+1)-1:0] o_row,
	output logic o_last_pixel
);

	localparam int COL_WIDTH = $clog2(FRAME_WIDTH);
	localparam int ROW_WIDTH = $clog2(FRAME_HEIGHT + 1);
	localparam logic [COL_WIDTH-1:0] LAST_COL = COL_WIDTH'(FRAME_WIDTH - 1);
	localparam logic [ROW_WIDTH-1:0] LAST_ROW = ROW_WIDTH'(FRAME_HEIGHT - 1);
	localparam logic [ROW_WIDTH-1:0] END_ROW = ROW_WIDTH'(FRAME_HEIGHT);

	// Position of the next pixel to be accepted
	always_ff @(posedge clk_os)
	begin
		if (!i_rst_n || i_clear)
		begin
			o_col <= '0;
			o_row <= '0;
		end
		else if (i_advance)
		begin
			if (o_col == LAST_COL)
			begin
				o_col <= '0;
				if (o_row != END_ROW) // Row stops one past the frame
				begin
					o_row <= o_row + 1'b1;
				end
			end
			else
			begin
				o_col <= o_col + 1'b1;
			end
		end
	end

	assign o_last_pixel = (o_col == LAST_COL) && (o_row == LAST_ROW);

endmodule

// ==== rtl/frame_ctrl.sv ====
`timescale 1ns/100ps

module frame_ctrl
#(
	parameter int FRAME_WIDTH = haar_pkg::DEF_FRAME_WIDTH,
	parameter int FRAME_HEIGHT = haar_pkg::DEF_FRAME_HEIGHT,
	parameter int WIN_WIDTH = haar_pkg::DEF_WIN_WIDTH,
	parameter int WIN_HEIGHT = haar_pkg::DEF_WIN_HEIGHT,
	parameter int CREDITS = haar_pkg::DEF_CREDITS
)
(
	input logic clk_os,
	input logic i_rst_n,
	input logic i_frame_start,
	input logic i_pixel_valid,
	input logic [$clog2(FRAME_WIDTH)-1:0] i_col,
	input logic [$clog2(FRAME_HEIGHT+1)-1:0] i_row,
	input logic i_last_pixel,
	output logic o_accept,
	output logic o_clear,
	output logic o_credit,
	output logic o_window_valid,
	output logic o_frame_done
);
	import haar_pkg::*;

	localparam int COL_WIDTH = $clog2(FRAME_WIDTH);
	localparam int ROW_WIDTH = $clog2(FRAME_HEIGHT + 1);
	localparam int CREDIT_CNT_WIDTH = $clog2(CREDITS + 1);
	localparam logic [COL_WIDTH-1:0] FIRST_WIN_COL = COL_WIDTH'(WIN_WIDTH - 1);
	localparam logic [ROW_WIDTH-1:0] FIRST_WIN_ROW = ROW_WIDTH'(WIN_HEIGHT - 1);

	frame_state_t state_q;
	frame_state_t state_next;
	logic [CREDIT_CNT_WIDTH-1:0] init_credits_q;
	logic rows_ready;
	logic win_hit;
	logic last_hit;
	logic [1:0] valid_pipe_q;
	logic [1:0] done_pipe_q;

	assign o_accept = i_pixel_valid && ((state_q == ST_FILL) || (state_q == ST_STREAM));
	assign o_clear = i_frame_start && ((state_q == ST_IDLE) || (state_q == ST_DONE));

	// Enough rows are buffered once streaming, or as soon as the row index gets there
	assign rows_ready = (state_q == ST_STREAM) || (i_row >= FIRST_WIN_ROW);
	assign win_hit = o_accept && rows_ready && (i_col >= FIRST_WIN_COL);
	assign last_hit = o_accept && i_last_pixel;

	always_comb
	begin
		state_next = state_q;
		case (state_q)
			ST_IDLE, ST_DONE:
			begin
				if (i_frame_start)
				begin
					state_next = ST_FILL;
				end
			end
			ST_FILL:
			begin
				if (last_hit) // Only for frames no taller than the window
				begin
					state_next = ST_DONE;
				end
				else if (i_row >= FIRST_WIN_ROW)
				begin
					state_next = ST_STREAM;
				end
			end
			ST_STREAM:
			begin
				if (last_hit)
				begin
					state_next = ST_DONE;
				end
			end
			default:
			begin
				state_next = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_os)
	begin
		if (!i_rst_n)
		begin
			state_q <= ST_IDLE;
		end
		else
		begin
			state_q <= state_next;
		end
	end

	// A pixel always returns its credit next cycle; the initial grant waits behind it.
	// Pixels sent outside a frame are dropped but still hand their credit back
	always_ff @(posedge clk_os)
	begin
		if (!i_rst_n)
		begin
			init_credits_q <= CREDIT_CNT_WIDTH'(CREDITS);
			o_credit <= 1'b0;
		end
		else
		begin
			o_credit <= i_pixel_valid || (init_credits_q != '0);
			if (!i_pixel_valid && (init_credits_q != '0))
			begin
				init_credits_q <= init_credits_q - 1'b1;
			end
		end
	end

	always_ff @(posedge clk_os)
	begin
		if (!i_rst_n)
		begin
			valid_pipe_q <= '0;
			done_pipe_q <= '0;
		end
		else
		begin
			valid_pipe_q <= {valid_pipe_q[0], win_hit}; // Shift stage then integral stage
			done_pipe_q <= {done_pipe_q[0], last_hit};
		end
	end

	assign o_window_valid = valid_pipe_q[1];
	assign o_frame_done = done_pipe_q[1];

endmodule

// ==== rtl/integral_row.sv ====
`timescale 1ns/100ps

module integral_row
#(
	parameter int FRAME_WIDTH = haar_pkg::DEF_FRAME_WIDTH,
	parameter int WIN_WIDTH = haar_pkg::DEF_WIN_WIDTH
)
(
	input logic clk_os,
	input logic i_rst_n,
	input logic i_shift,
	input haar_pkg::pixel_t i_pixel,
	input haar_pkg::sum_t [WIN_WIDTH-1:0] i_above_sum,
	output haar_pkg::pixel_t o_pixel_out,
	output logic o_shift_out,
	output haar_pkg::sum_t [WIN_WIDTH-1:0] o_col_sum,
	output haar_pkg::sum_t [WIN_WIDTH-1:0] o_row_integral
);
	import haar_pkg::*;

	pixel_t line_q [FRAME_WIDTH]; // Entry 0 is the newest pixel of this row
	sum_t [WIN_WIDTH-1:0] integral_next;
	sum_t run_sum;

	// One frame row of history, so the tail holds the same column one row back
	always_ff @(posedge clk_os)
	begin
		if (i_shift)
		begin
			line_q[0] <= i_pixel;
			for (int i = 1; i < FRAME_WIDTH; i++)
			begin
				line_q[i] <= line_q[i-1];
			end
		end
	end

	// Read before the shift, so the older row sees its pixel in the same cycle
	assign o_pixel_out = line_q[FRAME_WIDTH-1];
	assign o_shift_out = i_shift; // All rows move on the same accepted pixel

	// Window column 0 is the oldest, which sits deepest among the newest entries
	always_comb
	begin
		for (int c = 0; c < WIN_WIDTH; c++)
		begin
			o_col_sum[c] = i_above_sum[c] + sum_t'(line_q[WIN_WIDTH-1-c]);
		end
	end

	// Running sum over columns turns column sums into integral values
	always_comb
	begin
		run_sum = '0;
		for (int c = 0; c < WIN_WIDTH; c++)
		begin
			run_sum = run_sum + o_col_sum[c];
			integral_next[c] = run_sum;
		end
	end

	always_ff @(posedge clk_os)
	begin
		if (!i_rst_n)
		begin
			o_row_integral <= '0;
		end
		else
		begin
			o_row_integral <= integral_next;
		end
	end

endmodule

// ==== rtl/integral_window_memory.sv ====
`timescale 1ns/100ps

module integral_window_memory
#(
	parameter int FRAME_WIDTH = haar_pkg::DEF_FRAME_WIDTH,
	parameter int WIN_WIDTH = haar_pkg::DEF_WIN_WIDTH,
	parameter int WIN_HEIGHT = haar_pkg::DEF_WIN_HEIGHT
)
(
	input logic clk_os,
	input logic i_rst_n,
	input logic i_shift,
	input haar_pkg::pixel_t i_pixel,
	output haar_pkg::sum_t [WIN_WIDTH*WIN_HEIGHT-1:0] o_window
);
	import haar_pkg::*;

	// Chain index 0 is the newest frame row, WIN_HEIGHT-1 the oldest
	pixel_t pixel_chain [WIN_HEIGHT+1];
	logic [WIN_HEIGHT:0] shift_chain;
	sum_t [WIN_WIDTH-1:0] above_sum [WIN_HEIGHT];
	sum_t [WIN_WIDTH-1:0] col_sum [WIN_HEIGHT];
	sum_t [WIN_WIDTH-1:0] row_integral [WIN_HEIGHT];

	assign pixel_chain[0] = i_pixel;
	assign shift_chain[0] = i_shift;

	generate
		for (genvar k = 0; k < WIN_HEIGHT; k++)
		begin : g_row
			if (k < WIN_HEIGHT - 1)
			begin : g_newer
				assign above_sum[k] = col_sum[k+1]; // Column sums flow from older rows
			end
			else
			begin : g_oldest
				assign above_sum[k] = '0;
			end

			integral_row
			#(
				.FRAME_WIDTH(FRAME_WIDTH),
				.WIN_WIDTH(WIN_WIDTH)
			)
			u_row
			(
				.clk_os(clk_os),
				.i_rst_n(i_rst_n),
				.i_shift(shift_chain[k]),
				.i_pixel(pixel_chain[k]),
				.i_above_sum(above_sum[k]),
				.o_pixel_out(pixel_chain[k+1]),
				.o_shift_out(shift_chain[k+1]),
				.o_col_sum(col_sum[k]),
				.o_row_integral(row_integral[k])
			);

			// Window row 0 is the oldest frame row, hence the reversed index
			for (genvar c = 0; c < WIN_WIDTH; c++)
			begin : g_col
				assign o_window[c + WIN_WIDTH*(WIN_HEIGHT-1-k)] = row_integral[k][c];
			end
		end
	endgenerate

endmodule

// ==== rtl/haar_integral_top.sv ====
`timescale 1ns/100ps

module haar_integral_top
#(
	parameter int FRAME_WIDTH = haar_pkg::DEF_FRAME_WIDTH,
	parameter int FRAME_HEIGHT = haar_pkg::DEF_FRAME_HEIGHT,
	parameter int WIN_WIDTH = haar_pkg::DEF_WIN_WIDTH,
	parameter int WIN_HEIGHT = haar_pkg::DEF_WIN_HEIGHT,
	parameter int CREDITS = haar_pkg::DEF_CREDITS
)
(
	input logic clk_os,
	input logic i_rst_n,
	input logic i_frame_start,
	input logic i_pixel_valid,
	input haar_pkg::pixel_t i_pixel,
	output logic o_credit,
	output haar_pkg::sum_t [WIN_WIDTH*WIN_HEIGHT-1:0] o_window,
	output logic o_window_valid,
	output logic o_frame_done
);

	localparam int COL_WIDTH = $clog2(FRAME_WIDTH);
	localparam int ROW_WIDTH = $clog2(FRAME_HEIGHT + 1);

	logic accept;
	logic clear;
	logic last_pixel;
	logic [COL_WIDTH-1:0] col;
	logic [ROW_WIDTH-1:0] row;

	frame_ctrl
	#(
		.FRAME_WIDTH(FRAME_WIDTH),
		.FRAME_HEIGHT(FRAME_HEIGHT),
		.WIN_WIDTH(WIN_WIDTH),
		.WIN_HEIGHT(WIN_HEIGHT),
		.CREDITS(CREDITS)
	)
	u_frame_ctrl
	(
		.clk_os(clk_os),
		.i_rst_n(i_rst_n),
		.i_frame_start(i_frame_start),
		.i_pixel_valid(i_pixel_valid),
		.i_col(col),
		.i_row(row),
		.i_last_pixel(last_pixel),
		.o_accept(accept),
		.o_clear(clear),
		.o_credit(o_credit),
		.o_window_valid(o_window_valid),
		.o_frame_done(o_frame_done)
	);

	window_counter
	#(
		.FRAME_WIDTH(FRAME_WIDTH),
		.FRAME_HEIGHT(FRAME_HEIGHT)
	)
	u_window_counter
	(
		.clk_os(clk_os),
		.i_rst_n(i_rst_n),
		.i_clear(clear),
		.i_advance(accept),
		.o_col(col),
		.o_row(row),
		.o_last_pixel(last_pixel)
	);

	integral_window_memory
	#(
		.FRAME_WIDTH(FRAME_WIDTH),
		.WIN_WIDTH(WIN_WIDTH),
		.WIN_HEIGHT(WIN_HEIGHT)
	)
	u_window_memory
	(
		.clk_os(clk_os),
		.i_rst_n(i_rst_n),
		.i_shift(accept), // Only pixels inside a frame enter the line buffers
		.i_pixel(i_pixel),
		.o_window(o_window)
	);

endmodule

// ==== testbench/haar_integral_assertions.sv ====
`timescale 1ns/100ps

module haar_integral_assertions
#(
	parameter int CREDITS = haar_pkg::DEF_CREDITS
)
(
	input logic clk_os,
	input logic i_rst_n,
	input logic i_pixel_valid,
	input logic i_credit,
	input logic i_window_valid,
	input logic i_frame_done,
	input haar_pkg::frame_state_t i_state
);
	import haar_pkg::*;

	int sender_credits; // Credits held by the sender up to the previous cycle

	always_ff @(posedge clk_os)
	begin
		if (!i_rst_n)
		begin
			sender_credits <= 0;
		end
		else
		begin
			sender_credits <= sender_credits + int'(i_credit) - int'(i_pixel_valid);
		end
	end

	// A credit returned in this cycle may already be spent in it
	a_valid_has_credit: assert property (@(posedge clk_os) disable iff (!i_rst_n)
		i_pixel_valid |-> (sender_credits + int'(i_credit)) > 0)
		else $error("Pixel sent while the sender held no credit");

	a_credit_return: assert property (@(posedge clk_os) disable iff (!i_rst_n)
		i_pixel_valid |=> i_credit)
		else $error("Accepted pixel did not return its credit one cycle later");

	a_pool_bound: assert property (@(posedge clk_os) disable iff (!i_rst_n)
		sender_credits <= CREDITS)
		else $error("Sender holds more credits than the pool size");

	a_window_latency: assert property (@(posedge clk_os) disable iff (!i_rst_n)
		i_window_valid |-> $past(i_pixel_valid, 2)) // Shift stage then integral stage
		else $error("Window valid without a pixel sent two cycles earlier");

	a_done_state: assert property (@(posedge clk_os) disable iff (!i_rst_n)
		i_frame_done |-> (i_state == ST_DONE))
		else $error("Frame done pulsed outside the done state");

endmodule

bind frame_ctrl haar_integral_assertions
#(
	.CREDITS(CREDITS)
)
u_protocol_checks
(
	.clk_os(clk_os),
	.i_rst_n(i_rst_n),
	.i_pixel_valid(i_pixel_valid),
	.i_credit(o_credit),
	.i_window_valid(o_window_valid),
	.i_frame_done(o_frame_done),
	.i_state(state_q)
);

// ==== testbench/haar_integral_tb.sv ====
`timescale 1ns/100ps

module haar_integral_tb;
	import haar_pkg::*;

	localparam int FRAME_WIDTH = DEF_FRAME_WIDTH;
	localparam int FRAME_HEIGHT = DEF_FRAME_HEIGHT;
	localparam int WIN_WIDTH = DEF_WIN_WIDTH;
	localparam int WIN_HEIGHT = DEF_WIN_HEIGHT;
	localparam int CREDITS = DEF_CREDITS;
	localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;
	localparam int WINDOWS_PER_FRAME =
		(FRAME_HEIGHT - WIN_HEIGHT + 1) * (FRAME_WIDTH - WIN_WIDTH + 1);
	localparam int NUM_FRAMES = 2; // Both frames replay the same file
	localparam int RESET_CYCLES = 4;
	localparam int MAX_GAP = 15;
	localparam int WINDOW_BITS = WIN_WIDTH * WIN_HEIGHT * SUM_WIDTH;

	typedef logic [WINDOW_BITS-1:0] window_vec_t;

	logic clk_os;
	logic i_rst_n;
	logic i_frame_start;
	logic i_pixel_valid;
	pixel_t i_pixel;
	logic o_credit;
	sum_t [WIN_WIDTH*WIN_HEIGHT-1:0] o_window;
	logic o_window_valid;
	logic o_frame_done;

	logic [15:0] stim_mem [FRAME_PIXELS]; // Gap in the upper byte, pixel in the lower
	window_vec_t expected_q [$];
	int credits; // Credits the sender may still spend
	int windows_seen;
	logic frame_done_seen;
	logic frame_end_expected;
	int cycle_count;
	int timeout_cycles;

	haar_integral_top
	#(
		.FRAME_WIDTH(FRAME_WIDTH),
		.FRAME_HEIGHT(FRAME_HEIGHT),
		.WIN_WIDTH(WIN_WIDTH),
		.WIN_HEIGHT(WIN_HEIGHT),
		.CREDITS(CREDITS)
	)
	uut
	(
		.clk_os(clk_os),
		.i_rst_n(i_rst_n),
		.i_frame_start(i_frame_start),
		.i_pixel_valid(i_pixel_valid),
		.i_pixel(i_pixel),
		.o_credit(o_credit),
		.o_window(o_window),
		.o_window_valid(o_window_valid),
		.o_frame_done(o_frame_done)
	);

	initial
	begin
		clk_os = 1'b0;
		forever #2 clk_os = ~clk_os;
	end

	task automatic abort_run;
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped at the first failed check");
	endtask

	task automatic load_stimulus;
		int total_gaps;
		total_gaps = 0;
		for (int i = 0; i < FRAME_PIXELS; i++)
		begin
			stim_mem[i] = '1; // Any word left unread shows up as an oversized gap
		end
		$readmemh("testbench/haar_integral_stimulus.txt", stim_mem);
		for (int i = 0; i < FRAME_PIXELS; i++)
		begin
			assert (int'(stim_mem[i][15:8]) <= MAX_GAP)
			else
			begin
				$display("Stimulus file is missing or word %0d is malformed", i);
				abort_run();
			end
			total_gaps += int'(stim_mem[i][15:8]);
		end
		// Pixels, gaps and a few handshake cycles per frame, plus reset and credit grant
		timeout_cycles = NUM_FRAMES * (FRAME_PIXELS + total_gaps + 10) + 50;
	endtask

	// Integral over the window that ends at (row, col), straight from the frame pixels
	function automatic window_vec_t reference_window(input int row, input int col);
		window_vec_t win;
		int acc;
		int idx;
		win = '0;
		for (int wr = 0; wr < WIN_HEIGHT; wr++)
		begin
			for (int wc = 0; wc < WIN_WIDTH; wc++)
			begin
				acc = 0;
				for (int i = 0; i <= wr; i++)
				begin
					for (int j = 0; j <= wc; j++)
					begin
						idx = (row - WIN_HEIGHT + 1 + i) * FRAME_WIDTH + (col - WIN_WIDTH + 1 + j);
						acc += int'(stim_mem[idx][PIXEL_WIDTH-1:0]);
					end
				end
				win[(wc + WIN_WIDTH*wr)*SUM_WIDTH +: SUM_WIDTH] = SUM_WIDTH'(acc);
			end
		end
		return win;
	endfunction

	task automatic sample_outputs;
		window_vec_t expected;
		window_vec_t got;
		if (o_credit)
		begin
			credits++;
			assert (credits <= CREDITS)
			else
			begin
				$display("More credits came back than the sender had spent");
				abort_run();
			end
		end
		if (o_window_valid)
		begin
			assert (expected_q.size() > 0)
			else
			begin
				$display("Window valid while no window was due");
				abort_run();
			end
			expected = expected_q.pop_front();
			got = o_window;
			assert (got == expected)
			else
			begin
				$display("Error: o_window expected %h actual %h", expected, got);
				abort_run();
			end
			windows_seen++;
		end
		if (o_frame_done)
		begin
			assert (frame_end_expected && !frame_done_seen)
			else
			begin
				$display("Frame done pulsed before the last pixel or more than once");
				abort_run();
			end
			assert (expected_q.size() == 0 && windows_seen == WINDOWS_PER_FRAME)
			else
			begin
				$display("Frame done after %0d windows while %0d were due", windows_seen,
					WINDOWS_PER_FRAME);
				abort_run();
			end
			frame_done_seen = 1'b1;
		end
	endtask

	task automatic next_cycle;
		@(negedge clk_os);
		sample_outputs(); // Outputs settled at the rising edge half a cycle ago
	endtask

	task automatic send_pixel(input int idx);
		int row;
		int col;
		row = idx / FRAME_WIDTH;
		col = idx % FRAME_WIDTH;
		while (credits == 0)
		begin
			next_cycle();
		end
		i_pixel_valid = 1'b1;
		i_pixel = stim_mem[idx][PIXEL_WIDTH-1:0];
		credits--;
		if (row >= WIN_HEIGHT - 1 && col >= WIN_WIDTH - 1)
		begin
			expected_q.push_back(reference_window(row, col));
		end
		next_cycle();
		i_pixel_valid = 1'b0;
	endtask

	task automatic run_frame;
		windows_seen = 0;
		frame_done_seen = 1'b0;
		frame_end_expected = 1'b0;
		i_frame_start = 1'b1;
		next_cycle();
		i_frame_start = 1'b0;
		for (int idx = 0; idx < FRAME_PIXELS; idx++)
		begin
			repeat (int'(stim_mem[idx][15:8])) next_cycle();
			send_pixel(idx);
		end
		frame_end_expected = 1'b1;
		while (!frame_done_seen)
		begin
			next_cycle();
		end
		repeat (4) next_cycle(); // Room for a stray window or a second done pulse
		assert (credits == CREDITS)
		else
		begin
			$display("Sender holds %0d credits after the frame instead of %0d", credits, CREDITS);
			abort_run();
		end
	endtask

	initial
	begin
		cycle_count = 0;
		forever
		begin
			@(posedge clk_os);
			cycle_count++;
			if (cycle_count > timeout_cycles)
			begin
				$display("Timeout, the frames did not finish within %0d cycles", timeout_cycles);
				abort_run();
			end
		end
	end

	initial
	begin
		i_rst_n = 1'b0;
		i_frame_start = 1'b0;
		i_pixel_valid = 1'b0;
		i_pixel = '0;
		credits = 0;
		windows_seen = 0;
		frame_done_seen = 1'b0;
		frame_end_expected = 1'b0;
		load_stimulus();
		repeat (RESET_CYCLES) @(negedge clk_os);
		i_rst_n = 1'b1;
		while (credits < CREDITS)
		begin
			next_cycle();
		end
		repeat (3) next_cycle(); // An extra credit pulse would fail here
		for (int f = 0; f < NUM_FRAMES; f++)
		begin
			run_frame();
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== haar_integral_top.f ====
rtl/haar_pkg.sv
rtl/window_counter.sv
rtl/frame_ctrl.sv
rtl/integral_row.sv
rtl/integral_window_memory.sv
rtl/haar_integral_top.sv
testbench/haar_integral_assertions.sv
testbench/haar_integral_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the haar_integral testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module haar_integral_tb \
	-f haar_integral_top.f \
	-o haar_integral_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/haar_integral_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1

// ==== testbench/haar_integral_stimulus.txt ====
// One 16-bit word per pixel in raster order, ten words per frame row
// Upper byte is the idle gap in cycles before the pixel, lower byte the grey value
0012 00ff 0233 0047 00a0 0105 0066 00c3 0000 0391
00fe 0021 0088 0310 004c 00d7 0002 0199 0070 00ee
00ff 00ff 00ff 0201 003a 005b 00c4 0017 028e 0060
0001 0110 00b2 004d 00e9 0305 0073 00ff 0026 0058
0090 002f 00cc 0011 0264 0007 00ab 00f0 0139 0045
00ff 00ff 00ff 00ff 00ff 0300 0081 005e 00d2 0019
0140 0066 00bd 000c 0077 02ea 0031 009f 0050 00c8
00ff 00ff 00ff 0003 0115 0086 00da 0029 0344 00b7
0068 00ff 00ff 00ff 020e 0093 003c 00f5 0182 001b
00ff 00ff 00ff 0009 0256 00a1 0074 00cd 0113 0080
